// ==== dv/mem_arbiter_chk.sv ====
`timescale 1ns/1ps

module mem_arbiter_chk (
   input logic clk,
   input logic rst_n,
   input logic t_req,
   input logic t_we,
   input logic t_gnt,
   input logic t_rvalid,
   input logic s_req,
   input logic s_we,
   input logic s_gnt,
   input logic s_rvalid
);

   // --------------------------------------------------
   // Grant rules
   // --------------------------------------------------
   a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n) !(t_gnt && s_gnt))
      else $error("Both masters granted in the same cycle");
   a_t_gnt_req: assert property (@(posedge clk) disable iff (!rst_n) t_gnt |-> t_req)
      else $error("Tester granted without a request");
   a_s_gnt_req: assert property (@(posedge clk) disable iff (!rst_n) s_gnt |-> s_req)
      else $error("SUT granted without a request");

   // Read data one cycle after a read grant
   a_t_rd: assert property (@(posedge clk) disable iff (!rst_n)
      (t_gnt && !t_we) |=> t_rvalid) else $error("Tester read grant without rvalid");
   a_t_rv: assert property (@(posedge clk) disable iff (!rst_n)
      t_rvalid |-> $past(t_gnt && !t_we)) else $error("Tester rvalid without a read grant");
   a_s_rd: assert property (@(posedge clk) disable iff (!rst_n)
      (s_gnt && !s_we) |=> s_rvalid) else $error("SUT read grant without rvalid");
   a_s_rv: assert property (@(posedge clk) disable iff (!rst_n)
      s_rvalid |-> $past(s_gnt && !s_we)) else $error("SUT rvalid without a read grant");

endmodule

bind mem_arbiter mem_arbiter_chk u_arbiter_chk (
   .clk (clk), .rst_n (rst_n),
   .t_req (t_req), .t_we (t_we), .t_gnt (t_gnt), .t_rvalid (t_rvalid),
   .s_req (s_req), .s_we (s_we), .s_gnt (s_gnt), .s_rvalid (s_rvalid)
);

// ==== dv/tb_top_system.sv ====
`timescale 1ns/1ps

module tb_top_system;
   import tester_pkg::*;

   localparam int    N_OPS       = 15;
   localparam addr_t SUT_BASE    = 8'h80; // Outside the tester region
   localparam int    GNT_LIMIT   = 20;
   localparam int    RUN_LIMIT   = 200;
   localparam int    UART_LIMIT  = 40;    // Frame fully sent after trap
   localparam int    WATCHDOG_NS = (N_OPS * 10 + 4 * 200 + MEM_DEPTH) * 20;

   logic  clk, rst_n, start, verify;
   logic  sut_req, sut_we, sut_gnt, sut_rvalid;
   addr_t sut_addr;
   data_t sut_wdata, sut_rdata;
   logic  uart_txd, trap;

   // SUT operation table
   string op_name  [N_OPS];
   logic  op_we    [N_OPS];
   addr_t op_addr  [N_OPS];
   data_t op_wdata [N_OPS];
   data_t op_exp   [N_OPS];

   data_t ref_mem [MEM_DEPTH]; // Expected memory contents
   byte_t rx_q [$];            // Decoded UART characters
   data_t lcg_state = 32'h1c1b;
   int    check_cnt = 0;
   int    err_cnt   = 0;

   top_system i_dut (
      .clk (clk), .rst_n (rst_n), .start (start), .verify (verify),
      .sut_req (sut_req), .sut_we (sut_we), .sut_addr (sut_addr), .sut_wdata (sut_wdata),
      .sut_gnt (sut_gnt), .sut_rvalid (sut_rvalid), .sut_rdata (sut_rdata),
      .uart_txd (uart_txd), .trap (trap)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic data_t lcg_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check_val(input string name, input data_t exp, input data_t act);
      check_cnt++;
      assert (act === exp) else begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic set_op(input int idx, input string name, input logic we,
                         input addr_t addr, input data_t wdata);
      op_name[idx]  = name;
      op_we[idx]    = we;
      op_addr[idx]  = addr;
      op_wdata[idx] = wdata;
      if (we) begin
         ref_mem[addr] = wdata;
      end
      op_exp[idx] = ref_mem[addr]; // What a read sees at this point
   endtask

   task automatic build_table();
      data_t bad_val;
      foreach (ref_mem[a]) begin
         ref_mem[a] = '0; // Memory clears itself after reset
      end
      for (int i = 0; i < 4; i++) begin
         set_op(i, "clear_read", 1'b0, SUT_BASE + addr_t'(i), '0);
      end
      for (int i = 0; i < 4; i++) begin
         set_op(i + 4, "sut_write", 1'b1, SUT_BASE + addr_t'(i), lcg_rand());
      end
      for (int i = 0; i < 4; i++) begin
         set_op(i + 8, "read_back", 1'b0, SUT_BASE + addr_t'(i), '0);
      end
      bad_val = lcg_rand();
      if (bad_val == (data_t'(5) ^ PATTERN_KEY)) begin
         bad_val = ~bad_val;
      end
      set_op(12, "overwrite_5", 1'b1, 8'd5, bad_val);
      set_op(13, "read_5_sut", 1'b0, 8'd5, '0);
      ref_mem[5] = data_t'(5) ^ PATTERN_KEY; // Restore run rewrites the pattern
      set_op(14, "read_5_restored", 1'b0, 8'd5, '0);
   endtask

   // --------------------------------------------------
   // SUT master port driver
   // --------------------------------------------------
   task automatic apply_op(input int idx, input addr_t offset);
      int n;
      @(negedge clk);
      sut_req   = 1'b1;
      sut_we    = op_we[idx];
      sut_addr  = op_addr[idx] + offset;
      sut_wdata = op_wdata[idx];
      n = 0;
      @(negedge clk);
      while (!sut_gnt && n < GNT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      check_cnt++;
      assert (sut_gnt) else begin
         $display("%s: SUT request at %h got no grant", op_name[idx], sut_addr);
         err_cnt++;
      end
      @(negedge clk); // Cycle after the grant
      sut_req = 1'b0;
      if (!op_we[idx]) begin
         check_cnt++;
         assert (sut_rvalid) else begin
            $display("%s: no read data one cycle after the grant", op_name[idx]);
            err_cnt++;
         end
         check_val(op_name[idx], op_exp[idx], sut_rdata);
      end
   endtask

   task automatic run_tester(input logic is_verify, input byte_t exp_char, input string name);
      int n;
      @(negedge clk);
      start  = ~is_verify;
      verify = is_verify;
      @(negedge clk);
      start  = 1'b0;
      verify = 1'b0;
      check_val({name, "_trap_low"}, '0, data_t'(trap));
      n = 0;
      while (!trap && n < RUN_LIMIT) begin
         @(negedge clk);
         n++;
      end
      check_cnt++;
      assert (trap) else begin
         $display("%s: trap did not rise at the end of the run", name);
         err_cnt++;
      end
      n = 0;
      while (rx_q.size() == 0 && n < UART_LIMIT) begin
         @(negedge clk);
         n++;
      end
      check_cnt++;
      assert (rx_q.size() != 0) else begin
         $display("%s: no verdict character arrived on the UART", name);
         err_cnt++;
      end
      if (rx_q.size() != 0) begin
         check_val(name, data_t'(exp_char), data_t'(rx_q.pop_front()));
      end
   endtask

   // 8N1 decoder sampling near the middle of each bit
   initial begin : uart_decoder
      byte_t rx_byte;
      forever begin
         @(negedge uart_txd);
         repeat (CLKS_PER_BIT / 2) @(negedge clk);
         check_cnt++;
         assert (uart_txd == 1'b0) else begin
            $display("UART start bit did not stay low to its middle");
            err_cnt++;
         end
         for (int b = 0; b < 8; b++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            rx_byte[b] = uart_txd; // LSB first
         end
         repeat (CLKS_PER_BIT) @(negedge clk);
         check_cnt++;
         assert (uart_txd == 1'b1) else begin
            $display("UART stop bit was not high");
            err_cnt++;
         end
         rx_q.push_back(rx_byte);
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      rst_n     = 1'b0;
      start     = 1'b0;
      verify    = 1'b0;
      sut_req   = 1'b0;
      sut_we    = 1'b0;
      sut_addr  = '0;
      sut_wdata = '0;
      build_table();
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      repeat (MEM_DEPTH + 4) @(negedge clk); // Memory clear plus reset release
      check_val("reset_sut_gnt", '0, data_t'(sut_gnt));
      check_val("reset_sut_rvalid", '0, data_t'(sut_rvalid));
      check_val("reset_trap", '0, data_t'(trap));
      check_val("reset_uart_txd", data_t'(1), data_t'(uart_txd)); // Line idles high
      for (int i = 0; i < 12; i++) begin
         apply_op(i, 8'h00);
      end
      run_tester(1'b0, CHAR_PASS, "start_run");
      fork
         run_tester(1'b0, CHAR_PASS, "start_contended");
         for (int i = 0; i < 12; i++) begin
            apply_op(i, 8'h10); // Second SUT region
         end
      join
      apply_op(12, 8'h00);
      run_tester(1'b1, CHAR_FAIL, "verify_run");
      apply_op(13, 8'h00);
      run_tester(1'b0, CHAR_PASS, "restore_run");
      apply_op(14, 8'h00);
      $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
hdl/tester_pkg.sv
hdl/reset_sync.sv
hdl/shared_mem.sv
hdl/mem_arbiter.sv
hdl/tester_core.sv
hdl/uart_tx.sv
hdl/top_system.sv
dv/mem_arbiter_chk.sv
dv/tb_top_system.sv

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              t_req,
   input  logic              t_we,
   input  tester_pkg::addr_t t_addr,
   input  tester_pkg::data_t t_wdata,
   output logic              t_gnt,
   output logic              t_rvalid,
   output tester_pkg::data_t t_rdata,
   input  logic              s_req,
   input  logic              s_we,
   input  tester_pkg::addr_t s_addr,
   input  tester_pkg::data_t s_wdata,
   output logic              s_gnt,
   output logic              s_rvalid,
   output tester_pkg::data_t s_rdata,
   output logic              mem_en,
   output logic              mem_we,
   output tester_pkg::addr_t mem_addr,
   output tester_pkg::data_t mem_wdata,
   input  tester_pkg::data_t mem_rdata
);
   import tester_pkg::*;

   logic last_s; // SUT granted last
   logic t_elig, s_elig;
   logic t_next, s_next;

   // A master in its grant cycle still shows the old request
   assign t_elig = t_req & ~t_gnt;
   assign s_elig = s_req & ~s_gnt;
   assign t_next = t_elig & (~s_elig | last_s);
   assign s_next = s_elig & (~t_elig | ~last_s);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         t_gnt    <= 1'b0;
         s_gnt    <= 1'b0;
         t_rvalid <= 1'b0;
         s_rvalid <= 1'b0;
         last_s   <= 1'b0;
      end else begin
         t_gnt    <= t_next;
         s_gnt    <= s_next;
         t_rvalid <= t_gnt & ~t_we; // Read data returns to its issuer
         s_rvalid <= s_gnt & ~s_we;
         if (t_next || s_next) begin
            last_s <= s_next;
         end
      end
   end

   // ------------------------------------------------
   // Memory port mux with the access in the grant cycle
   // ------------------------------------------------
   assign mem_en    = t_gnt | s_gnt;
   assign mem_we    = (t_gnt & t_we) | (s_gnt & s_we);
   assign mem_addr  = s_gnt ? s_addr : t_addr;
   assign mem_wdata = s_gnt ? s_wdata : t_wdata;
   assign t_rdata   = mem_rdata;
   assign s_rdata   = mem_rdata;

endmodule

// ==== hdl/reset_sync.sv ====
`timescale 1ns/1ps

module reset_sync (
   input  logic clk,
   input  logic rst_n,
   input  logic init_done,
   output logic sys_rst_n
);

   logic [1:0] sync_q;
   logic       rst_ok;

   assign rst_ok = rst_n & init_done; // Board reset released and memory ready

   always_ff @(posedge clk) begin
      if (!rst_ok) begin
         sync_q <= 2'b00; // Asserts on the next edge
      end else begin
         sync_q <= {sync_q[0], 1'b1};
      end
   end

   assign sys_rst_n = sync_q[1];

endmodule

// ==== hdl/shared_mem.sv ====
`timescale 1ns/1ps

module shared_mem (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              mem_en,
   input  logic              mem_we,
   input  tester_pkg::addr_t mem_addr,
   input  tester_pkg::data_t mem_wdata,
   output tester_pkg::data_t mem_rdata,
   output logic              init_done
);
   import tester_pkg::*;

   data_t mem [0:MEM_DEPTH-1];
   addr_t clr_addr;

   // ------------------------------------------------
   // Self-clear sequencer
   // ------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         clr_addr  <= '0;
         init_done <= 1'b0;
      end else if (!init_done) begin
         clr_addr <= clr_addr + 1'b1;
         if (clr_addr == addr_t'(MEM_DEPTH - 1)) begin
            init_done <= 1'b1; // Last word cleared
         end
      end
   end

   // Storage array with registered read
   always_ff @(posedge clk) begin
      if (!init_done) begin
         mem[clr_addr] <= '0; // Clear sweep owns the array
      end else if (mem_en && mem_we) begin
         mem[mem_addr] <= mem_wdata;
      end

      if (mem_en && init_done) begin
         mem_rdata <= mem[mem_addr];
      end
   end

endmodule

// ==== hdl/tester_core.sv ====
`timescale 1ns/1ps

module tester_core (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              start,
   input  logic              verify,
   output logic              req,
   output logic              we,
   output tester_pkg::addr_t addr,
   output tester_pkg::data_t wdata,
   input  logic              gnt,
   input  logic              rvalid,
   input  tester_pkg::data_t rdata,
   output tester_pkg::byte_t tx_char,
   output logic              tx_start,
   output logic              done
);
   import tester_pkg::*;

   tester_state_t    state;
   addr_t            idx;
   logic [ERR_W-1:0] err_cnt;
   data_t            pattern;
   logic             last_word;

   assign addr      = addr_t'(TEST_BASE) + idx;
   assign pattern   = data_t'(addr) ^ PATTERN_KEY; // Word owned by this address
   assign last_word = (idx == addr_t'(TEST_LEN - 1));

   // Request held by state until granted
   assign req   = (state == T_WRITE) || (state == T_READ);
   assign we    = (state == T_WRITE);
   assign wdata = pattern;

   // ------------------------------------------------
   // Test sequencer
   // ------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= T_IDLE;
         idx      <= '0;
         err_cnt  <= '0;
         tx_start <= 1'b0;
         done     <= 1'b0;
      end else begin
         tx_start <= 1'b0;
         case (state)
            T_IDLE, T_DONE: begin
               if (start || verify) begin
                  done    <= 1'b0;
                  idx     <= '0;
                  err_cnt <= '0;
                  state   <= start ? T_WRITE : T_READ; // Verify skips the fill
               end else if (state == T_DONE) begin
                  done <= 1'b1;
               end
            end
            T_WRITE: begin
               if (gnt) begin
                  if (last_word) begin
                     idx   <= '0;
                     state <= T_READ;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            T_READ: begin
               if (gnt) begin
                  state <= T_WAIT_DATA;
               end
            end
            T_WAIT_DATA: begin
               if (rvalid) begin
                  if (rdata != pattern) begin
                     err_cnt <= err_cnt + 1'b1;
                  end
                  if (last_word) begin
                     state <= T_REPORT;
                  end else begin
                     idx   <= idx + 1'b1;
                     state <= T_READ;
                  end
               end
            end
            T_REPORT: begin
               tx_start <= 1'b1; // done follows one cycle later
               state    <= T_DONE;
            end
            default: state <= T_IDLE;
         endcase
      end
   end

   // Verdict character
   always_ff @(posedge clk) begin
      if (state == T_REPORT) begin
         tx_char <= (err_cnt == '0) ? CHAR_PASS : CHAR_FAIL;
      end
   end

endmodule

// ==== hdl/tester_pkg.sv ====
package tester_pkg;

   // ------------------------------------------------
   // Memory geometry
   // ------------------------------------------------
   localparam int ADDR_W    = 8;
   localparam int DATA_W    = 32;
   localparam int MEM_DEPTH = 256;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [7:0]        byte_t;

   // Tester region and pattern
   localparam int    TEST_BASE   = 0;
   localparam int    TEST_LEN    = 16;
   localparam int    ERR_W       = $clog2(TEST_LEN + 1); // Holds a full mismatch count
   localparam data_t PATTERN_KEY = 32'h5a3c_0f96;

   // UART timing and verdict characters
   localparam int    CLKS_PER_BIT = 4;
   localparam int    TICK_W       = $clog2(CLKS_PER_BIT);
   localparam byte_t CHAR_PASS    = 8'h50; // 'P'
   localparam byte_t CHAR_FAIL    = 8'h46; // 'F'

   // ------------------------------------------------
   // State encodings
   // ------------------------------------------------
   typedef enum logic [2:0] {
      T_IDLE, T_WRITE, T_READ, T_WAIT_DATA, T_REPORT, T_DONE
   } tester_state_t;

   typedef enum logic [1:0] {U_IDLE, U_START, U_DATA, U_STOP} uart_state_t;

endpackage

// ==== hdl/top_system.sv ====
`timescale 1ns/1ps

module top_system (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              start,
   input  logic              verify,
   input  logic              sut_req,
   input  logic              sut_we,
   input  tester_pkg::addr_t sut_addr,
   input  tester_pkg::data_t sut_wdata,
   output logic              sut_gnt,
   output logic              sut_rvalid,
   output tester_pkg::data_t sut_rdata,
   output logic              uart_txd,
   output logic              trap
);
   import tester_pkg::*;

   // ------------------------------------------------
   // Reset and memory model
   // ------------------------------------------------
   logic  sys_rst_n;
   logic  init_done;
   logic  mem_en, mem_we;
   addr_t mem_addr;
   data_t mem_wdata, mem_rdata;

   // Tester master port
   logic  t_req, t_we, t_gnt, t_rvalid;
   addr_t t_addr;
   data_t t_wdata, t_rdata;

   // Verdict path
   byte_t tx_char;
   logic  tx_start;

   reset_sync u_reset_sync (
      .clk       (clk),
      .rst_n     (rst_n),
      .init_done (init_done),
      .sys_rst_n (sys_rst_n)
   );

   shared_mem u_shared_mem (
      .clk       (clk),
      .rst_n     (rst_n), // Clears before the system comes up
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata),
      .init_done (init_done)
   );

   mem_arbiter u_mem_arbiter (
      .clk (clk), .rst_n (sys_rst_n),
      .t_req (t_req), .t_we (t_we), .t_addr (t_addr), .t_wdata (t_wdata),
      .t_gnt (t_gnt), .t_rvalid (t_rvalid), .t_rdata (t_rdata),
      .s_req (sut_req), .s_we (sut_we), .s_addr (sut_addr), .s_wdata (sut_wdata),
      .s_gnt (sut_gnt), .s_rvalid (sut_rvalid), .s_rdata (sut_rdata),
      .mem_en (mem_en), .mem_we (mem_we), .mem_addr (mem_addr),
      .mem_wdata (mem_wdata), .mem_rdata (mem_rdata)
   );

   tester_core u_tester_core (
      .clk (clk), .rst_n (sys_rst_n), .start (start), .verify (verify),
      .req (t_req), .we (t_we), .addr (t_addr), .wdata (t_wdata),
      .gnt (t_gnt), .rvalid (t_rvalid), .rdata (t_rdata),
      .tx_char (tx_char), .tx_start (tx_start),
      .done (trap) // End of run straight to the board
   );

   uart_tx u_uart_tx (
      .clk (clk), .rst_n (sys_rst_n),
      .tx_start (tx_start), .tx_char (tx_char),
      .txd (uart_txd), .busy ()
   );

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              tx_start,
   input  tester_pkg::byte_t tx_char,
   output logic              txd,
   output logic              busy
);
   import tester_pkg::*;

   uart_state_t       state;
   logic [TICK_W-1:0] tick;
   logic [2:0]        bit_idx;
   byte_t             shreg;
   logic              bit_end;

   assign bit_end = (tick == TICK_W'(CLKS_PER_BIT - 1));
   assign busy    = (state != U_IDLE);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= U_IDLE;
         tick    <= '0;
         bit_idx <= '0;
         txd     <= 1'b1; // Line idles high
      end else begin
         tick <= bit_end ? '0 : tick + 1'b1;
         case (state)
            U_IDLE: begin
               tick <= '0;
               if (tx_start) begin
                  shreg <= tx_char;
                  txd   <= 1'b0; // Start bit
                  state <= U_START;
               end
            end
            U_START: begin
               if (bit_end) begin
                  txd     <= shreg[0]; // LSB first
                  shreg   <= shreg >> 1;
                  bit_idx <= '0;
                  state   <= U_DATA;
               end
            end
            U_DATA: begin
               if (bit_end) begin
                  if (bit_idx == 3'd7) begin
                     txd   <= 1'b1; // Stop bit
                     state <= U_STOP;
                  end else begin
                     txd     <= shreg[0];
                     shreg   <= shreg >> 1;
                     bit_idx <= bit_idx + 1'b1;
                  end
               end
            end
            U_STOP: begin
               if (bit_end) begin
                  state <= U_IDLE;
               end
            end
            default: state <= U_IDLE;
         endcase
      end
   end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log for the pass message

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f flist.f \
      --top-module tb_top_system -o sim_top_system; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/sim_top_system > "$LOG" 2>&1; then
   cat "$LOG"
   echo "Simulation exited with an error status"
   exit 1
fi

cat "$LOG"
if grep -q "All tests passed" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
